// ==== design/upd7800_consts.svh ====
// Constants for the uPD7800 slice
// Widths, reset values, sampling tick and interrupt vectors

`ifndef UPD7800_CONSTS_SVH
`define UPD7800_CONSTS_SVH

`define UPD_DATA_W      8
`define UPD_NUM_INT     3

// Interrupt sampling tick, in CLK cycles
`define UPD_TICK_DIV    12

// mb, mc and mk come out of reset as all ones
`define UPD_MODE_RESET  8'hFF

// Interrupt vectors
`define UPD_VEC_INT0    8'h04
`define UPD_VEC_INT1    8'h10
`define UPD_VEC_INT2    8'h20
`define UPD_VEC_SOFTI   8'h60

// mk bit that selects INT2 polarity
`define UPD_MK_INT2_POL 5

`endif

// ==== design/upd7800_pkg.sv ====
// Shared types for the uPD7800 datapath and peripheral slice
// Data byte, special-register codes, ALU controls and interrupt indices

`include "upd7800_consts.svh"

package upd7800_pkg;

  // One data value on the internal bus
  typedef logic [`UPD_DATA_W-1:0] t_byte;

  // Special-register select codes, 6 and 7 unused
  typedef enum logic [2:0] {
    SPR_PA = 3'd0,
    SPR_PB = 3'd1,
    SPR_PC = 3'd2,
    SPR_MK = 3'd3,
    SPR_MB = 3'd4,
    SPR_MC = 3'd5
  } e_spr;

  // ALU operations
  typedef enum logic [3:0] {
    ALU_SUM,
    ALU_INC,
    ALU_DEC,
    ALU_OR,
    ALU_AND,
    ALU_EOR,
    ALU_LSL,
    ALU_ROL,
    ALU_LSR,
    ALU_ROR
  } e_alu_op;

  // Carry-in source for sums and rotates
  typedef enum logic [1:0] {
    CIN_NONE,
    CIN_ONE,
    CIN_CCO,
    CIN_PSW_CY
  } e_cin_sel;

  // External interrupt sources, lowest index wins
  typedef enum logic [1:0] {
    INT_IDX_0 = 2'd0,
    INT_IDX_1 = 2'd1,
    INT_IDX_2 = 2'd2
  } e_int_idx;

endpackage

// ==== design/spr_bus_if.sv ====
// Special-register bus
// Select, write data and strobe from the host, read data and mask back

`timescale 1ns/1ns

interface spr_bus_if;
  import upd7800_pkg::*;

  e_spr  sel;
  t_byte wdata;
  logic  we;
  t_byte rdata;
  // Interrupt mask, owned by the interrupt controller
  t_byte mk;

  modport host (output sel, output wdata, output we, input rdata);

  modport port_side (input sel, input wdata, input we, input mk, output rdata);

  modport mask_side (input sel, input wdata, input we, output mk);

endinterface

// ==== design/alu_unit.sv ====
// 8-bit ALU with operand latches and PSW flags
// Split-nibble adder, logic ops, shifts and decimal adjust

`timescale 1ns/1ns

module alu_unit (
  input  logic                  CLK,
  input  logic                  rst_n,
  input  upd7800_pkg::t_byte    op_data,
  input  logic                  ai_we,
  input  logic                  bi_we,
  input  logic                  alu_go,
  input  upd7800_pkg::e_alu_op  alu_op,
  input  upd7800_pkg::e_cin_sel cin_sel,
  input  logic                  bi_not,
  input  logic                  daa,
  input  logic                  psw_upd,
  output upd7800_pkg::t_byte    alu_result,
  output upd7800_pkg::t_byte    psw
);
  import upd7800_pkg::*;

  t_byte      ai, bi, ibi, co, res_nxt;
  logic       cco, cho, cco_nxt, cho_nxt;
  logic       z_flag, hc_flag, cy_flag;
  logic       addc, notbi, is_add;
  logic       pdah, pdal, pdac;
  logic [4:0] lsum, hsum;

  //////////////////////////////////////////////////
  // Operand latches

  always_ff @(posedge CLK) begin
    if (ai_we)
      ai <= op_data;
    if (bi_we)
      bi <= op_data;
  end

  //////////////////////////////////////////////////
  // Operand conditioning

  always_comb begin
    case (cin_sel)
      CIN_ONE:    addc = 1'b1;
      CIN_CCO:    addc = cco;
      CIN_PSW_CY: addc = cy_flag;
      default:    addc = 1'b0;
    endcase
    // INC always adds one
    if (alu_op == ALU_INC)
      addc = 1'b1;
  end

  assign notbi  = bi_not | (alu_op == ALU_DEC);
  assign is_add = (alu_op == ALU_SUM) | (alu_op == ALU_INC) | (alu_op == ALU_DEC);

  // Decimal adjust decisions from the PSW flags
  assign pdal = hc_flag | (ai[3:0] > 4'h9);
  assign pdah = cy_flag | (ai[7:4] > 4'h9) |
                (~hc_flag & (ai[3:0] > 4'h9) & (ai[7:4] == 4'h9));
  assign pdac = cy_flag | pdah;

  always_comb begin
    ibi = bi;
    if ((alu_op == ALU_INC) || (alu_op == ALU_DEC))
      ibi = '0;
    // Adjust constants replace b
    if (daa)
      ibi = {(pdah ? 4'h6 : 4'h0), (pdal ? 4'h6 : 4'h0)};
    ibi = ibi ^ {8{notbi}};
  end

  // Low nibble carries into high nibble
  assign lsum = {1'b0, ai[3:0]} + {1'b0, ibi[3:0]} + {4'b0, addc};
  assign hsum = {1'b0, ai[7:4]} + {1'b0, ibi[7:4]} + {4'b0, lsum[4]};

  //////////////////////////////////////////////////
  // Result select

  always_comb begin
    res_nxt = co;
    cco_nxt = cco;
    cho_nxt = cho;
    if (is_add) begin
      res_nxt = {hsum[3:0], lsum[3:0]};
      cco_nxt = daa ? pdac : hsum[4];
      cho_nxt = (lsum > 5'd9);
    end else begin
      case (alu_op)
        ALU_OR:  res_nxt = ai | ibi;
        ALU_AND: res_nxt = ai & ibi;
        ALU_EOR: res_nxt = ai ^ ibi;
        ALU_LSL,
        ALU_ROL: {cco_nxt, res_nxt} = {ai, addc & (alu_op == ALU_ROL)};
        ALU_LSR,
        ALU_ROR: {res_nxt, cco_nxt} = {addc & (alu_op == ALU_ROR), ai};
        default: res_nxt = co;
      endcase
    end
  end

  // Result register, one result in flight
  always_ff @(posedge CLK) begin
    if (alu_go)
      co <= res_nxt;
  end

  // Logic ops leave the carries alone
  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      cco <= 1'b0;
      cho <= 1'b0;
    end else if (alu_go) begin
      cco <= cco_nxt;
      cho <= cho_nxt;
    end
  end

  //////////////////////////////////////////////////
  // PSW flags

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      z_flag  <= 1'b0;
      hc_flag <= 1'b0;
      cy_flag <= 1'b0;
    end else if (psw_upd) begin
      z_flag  <= ~|co;
      hc_flag <= cho;
      cy_flag <= cco;
    end
  end

  // Z in bit 6, HC in bit 4, CY in bit 0
  assign psw        = {1'b0, z_flag, 1'b0, hc_flag, 3'b000, cy_flag};
  assign alu_result = co;

  a_daa_only_sum: assert property (@(posedge CLK) disable iff (!rst_n)
    (alu_go && daa) |-> (alu_op == ALU_SUM))
    else $error("daa issued with a non-SUM operation");

endmodule

// ==== design/int_ctrl.sv ====
// Interrupt controller for INT0, INT1 and INT2
// Tick sampling, pending bits, mask and enable, priority and vector

`timescale 1ns/1ns

`include "upd7800_consts.svh"

module int_ctrl (
  input  logic               CLK,
  input  logic               rst_n,
  input  logic               int0,
  input  logic               int1,
  input  logic               int2,
  input  logic               fetch_start,
  input  logic               int_ack,
  input  logic               ie_we,
  input  logic               ie_val,
  spr_bus_if.mask_side       spr,
  output logic               int_req,
  output upd7800_pkg::t_byte int_vector
);
  import upd7800_pkg::*;

  logic [3:0]              tick_cnt;
  logic                    tick;
  logic [3:0]              intv1, intv2;
  logic                    int2_smp;
  logic [`UPD_NUM_INT-1:0] pend, latched, enabled, ack_sel, set_edge;
  logic                    ie;
  t_byte                   mk;

  //////////////////////////////////////////////////
  // Sampling tick

  assign tick = (tick_cnt == 4'(`UPD_TICK_DIV - 1));

  always_ff @(posedge CLK) begin
    if (!rst_n)
      tick_cnt <= '0;
    else
      tick_cnt <= tick ? '0 : tick_cnt + 4'd1;
  end

  // mk bit 5 clear means INT2 is active low
  assign int2_smp = int2 ^ ~mk[`UPD_MK_INT2_POL];

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      intv1 <= '0;
      intv2 <= '0;
    end else if (tick) begin
      intv1 <= {intv1[2:0], int1};
      intv2 <= {intv2[2:0], int2_smp};
    end
  end

  // Edge seen as one low sample then three high
  always_comb begin
    set_edge = '0;
    set_edge[INT_IDX_1] = tick & (intv1 == 4'b0111);
    set_edge[INT_IDX_2] = tick & (intv2 == 4'b0111);
  end

  //////////////////////////////////////////////////
  // Pending, mask and enable

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      pend <= '0;
    end else begin
      pend <= (pend & ~(ack_sel & {`UPD_NUM_INT{int_ack}})) | set_edge;
      // INT0 is level sensitive
      pend[INT_IDX_0] <= int0 & ~(int_ack & ack_sel[INT_IDX_0]);
    end
  end

  always_ff @(posedge CLK) begin
    if (!rst_n)
      mk <= `UPD_MODE_RESET;
    else if (spr.we && (spr.sel == SPR_MK))
      mk <= spr.wdata;
  end

  assign spr.mk = mk;

  always_ff @(posedge CLK) begin
    if (!rst_n)
      ie <= 1'b0;
    else if (int_ack)
      ie <= 1'b0;
    else if (ie_we)
      ie <= ie_val;
  end

  // mk bits 0, 2 and 3 mask INT0, INT1 and INT2
  always_comb begin
    enabled = '0;
    enabled[INT_IDX_0] = ie & ~mk[0];
    enabled[INT_IDX_1] = ie & ~mk[2];
    enabled[INT_IDX_2] = ie & ~mk[3];
  end

  //////////////////////////////////////////////////
  // Latch at fetch, priority and vector

  always_ff @(posedge CLK) begin
    if (!rst_n)
      latched <= '0;
    else if (fetch_start)
      latched <= pend & enabled;
    else if (int_ack)
      latched <= latched & ~ack_sel;
  end

  // Fixed priority, INT0 first
  always_comb begin
    ack_sel = '0;
    if (latched[INT_IDX_0])
      ack_sel[INT_IDX_0] = 1'b1;
    else if (latched[INT_IDX_1])
      ack_sel[INT_IDX_1] = 1'b1;
    else if (latched[INT_IDX_2])
      ack_sel[INT_IDX_2] = 1'b1;
  end

  always_comb begin
    case (1'b1)
      ack_sel[INT_IDX_0]: int_vector = `UPD_VEC_INT0;
      ack_sel[INT_IDX_1]: int_vector = `UPD_VEC_INT1;
      ack_sel[INT_IDX_2]: int_vector = `UPD_VEC_INT2;
      default:            int_vector = `UPD_VEC_SOFTI;
    endcase
  end

  assign int_req = |latched;

  a_ack_with_req: assert property (@(posedge CLK) disable iff (!rst_n)
    int_ack |-> int_req)
    else $error("int_ack without a latched request");

endmodule

// ==== design/port_regs.sv ====
// Port A/B/C output registers with port B/C mode registers
// Also the read multiplexer of the special-register bus

`timescale 1ns/1ns

`include "upd7800_consts.svh"

module port_regs (
  input  logic               CLK,
  input  logic               rst_n,
  input  upd7800_pkg::t_byte pb_in,
  input  upd7800_pkg::t_byte pc_in,
  spr_bus_if.port_side       spr,
  output upd7800_pkg::t_byte pa_out,
  output upd7800_pkg::t_byte pb_out,
  output upd7800_pkg::t_byte pb_oe,
  output upd7800_pkg::t_byte pc_out,
  output upd7800_pkg::t_byte pc_oe
);
  import upd7800_pkg::*;

  t_byte pa, pb, pc, mb, mc;
  t_byte rdata;

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      pa <= '0;
      pb <= '0;
      pc <= '0;
      mb <= `UPD_MODE_RESET;
      mc <= `UPD_MODE_RESET;
    end else if (spr.we) begin
      case (spr.sel)
        SPR_PA:  pa <= spr.wdata;
        SPR_PB:  pb <= spr.wdata;
        SPR_PC:  pc <= spr.wdata;
        SPR_MB:  mb <= spr.wdata;
        SPR_MC:  mc <= spr.wdata;
        default: ;
      endcase
    end
  end

  // Mode bit set means input
  assign pb_oe = ~mb;
  // Bits 6..3 always drive, bit 2 never
  assign pc_oe = {~mc[7], 4'b1111, 1'b0, ~mc[1:0]};

  assign pa_out = pa;
  assign pb_out = pb;
  assign pc_out = pc;

  //////////////////////////////////////////////////
  // Read mux, pins on input bits

  always_comb begin
    case (spr.sel)
      SPR_PA:  rdata = pa;
      SPR_PB:  rdata = (pb_in & ~pb_oe) | (pb & pb_oe);
      SPR_PC:  rdata = (pc_in & ~pc_oe) | (pc & pc_oe);
      SPR_MK:  rdata = spr.mk;
      SPR_MB:  rdata = mb;
      SPR_MC:  rdata = mc;
      default: rdata = '0;
    endcase
  end

  assign spr.rdata = rdata;

  a_no_bad_sel: assert property (@(posedge CLK) disable iff (!rst_n)
    spr.we |-> (spr.sel <= SPR_MC))
    else $error("special-register write to an unused code");

endmodule

// ==== design/upd7800_slice.sv ====
// uPD7800 datapath and peripheral slice, top level
// ALU, interrupt controller and port registers on one special-register bus

`timescale 1ns/1ns

module upd7800_slice (
  input  logic                  CLK,
  input  logic                  rst_n,
  input  upd7800_pkg::e_spr     spr_sel,
  input  upd7800_pkg::t_byte    spr_wdata,
  input  logic                  spr_we,
  input  upd7800_pkg::t_byte    op_data,
  input  logic                  ai_we,
  input  logic                  bi_we,
  input  logic                  alu_go,
  input  upd7800_pkg::e_alu_op  alu_op,
  input  upd7800_pkg::e_cin_sel cin_sel,
  input  logic                  bi_not,
  input  logic                  daa,
  input  logic                  psw_upd,
  input  logic                  int0,
  input  logic                  int1,
  input  logic                  int2,
  input  logic                  fetch_start,
  input  logic                  int_ack,
  input  logic                  ie_we,
  input  logic                  ie_val,
  input  upd7800_pkg::t_byte    pb_in,
  input  upd7800_pkg::t_byte    pc_in,
  output upd7800_pkg::t_byte    spr_rdata,
  output upd7800_pkg::t_byte    alu_result,
  output upd7800_pkg::t_byte    psw,
  output logic                  int_req,
  output upd7800_pkg::t_byte    int_vector,
  output upd7800_pkg::t_byte    pa_out,
  output upd7800_pkg::t_byte    pb_out,
  output upd7800_pkg::t_byte    pb_oe,
  output upd7800_pkg::t_byte    pc_out,
  output upd7800_pkg::t_byte    pc_oe
);

  spr_bus_if spr ();

  // Host side of the bus comes straight from the ports
  assign spr.sel   = spr_sel;
  assign spr.wdata = spr_wdata;
  assign spr.we    = spr_we;
  assign spr_rdata = spr.rdata;

  alu_unit i_alu (
    .CLK        (CLK),
    .rst_n      (rst_n),
    .op_data    (op_data),
    .ai_we      (ai_we),
    .bi_we      (bi_we),
    .alu_go     (alu_go),
    .alu_op     (alu_op),
    .cin_sel    (cin_sel),
    .bi_not     (bi_not),
    .daa        (daa),
    .psw_upd    (psw_upd),
    .alu_result (alu_result),
    .psw        (psw)
  );

  int_ctrl i_int (
    .CLK         (CLK),
    .rst_n       (rst_n),
    .int0        (int0),
    .int1        (int1),
    .int2        (int2),
    .fetch_start (fetch_start),
    .int_ack     (int_ack),
    .ie_we       (ie_we),
    .ie_val      (ie_val),
    .spr         (spr.mask_side),
    .int_req     (int_req),
    .int_vector  (int_vector)
  );

  port_regs i_ports (
    .CLK    (CLK),
    .rst_n  (rst_n),
    .pb_in  (pb_in),
    .pc_in  (pc_in),
    .spr    (spr.port_side),
    .pa_out (pa_out),
    .pb_out (pb_out),
    .pb_oe  (pb_oe),
    .pc_out (pc_out),
    .pc_oe  (pc_oe)
  );

endmodule

// ==== tests/tb_upd7800_slice.sv ====
// Testbench for the uPD7800 datapath and peripheral slice
// Random ALU, special-register and interrupt traffic checked against a behavioral model

`timescale 1ns/1ns

`include "upd7800_consts.svh"

module tb_upd7800_slice;
  import upd7800_pkg::*;

  // About four times the combined length of all tests
  localparam int CYCLE_LIMIT = 20000;

  logic     CLK;
  logic     rst_n;
  e_spr     spr_sel;
  t_byte    spr_wdata;
  logic     spr_we;
  t_byte    op_data;
  logic     ai_we, bi_we, alu_go;
  e_alu_op  alu_op;
  e_cin_sel cin_sel;
  logic     bi_not, daa, psw_upd;
  logic     int0, int1, int2;
  logic     fetch_start, int_ack, ie_we, ie_val;
  t_byte    pb_in, pc_in;
  t_byte    spr_rdata, alu_result, psw, int_vector;
  logic     int_req;
  t_byte    pa_out, pb_out, pb_oe, pc_out, pc_oe;

  integer seed;
  int     cycles = 0;
  int     errors = 0;
  int     checks = 0;

  // Reference model state
  t_byte      m_res;
  logic       m_cco, m_cho, m_cy, m_hc;
  t_byte      m_pa, m_pb, m_pc, m_mk, m_mb, m_mc;
  logic [2:0] m_pend, m_latched;
  logic       m_ie;

  upd7800_slice i_dut (.*);

  initial begin
    CLK = 1'b0;
    forever #4 CLK = ~CLK;
  end

  always @(posedge CLK) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("errors: %0d mismatches in %0d checks", errors, checks);
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  //////////////////////////////////////////////////
  // Helpers

  function automatic int unsigned rand_below(int unsigned n);
    return $unsigned($random(seed)) % n;
  endfunction

  task automatic compare(input string what, input t_byte got, input t_byte exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("mismatch at %0t ns: %s got %h, expected %h", $time, what, got, exp);
    end
  endtask

  // Adjust byte and carry from CY, HC and the two digits
  function automatic logic [8:0] daa_table(t_byte a, logic cy, logic hc);
    logic [3:0] hi;
    logic [3:0] lo;
    hi = a[7:4];
    lo = a[3:0];
    if (cy)
      return {1'b1, (hc || lo > 4'd9) ? 8'h66 : 8'h60};
    if (hc)
      return (hi > 4'd9) ? 9'h166 : 9'h006;
    if (lo <= 4'd9)
      return (hi <= 4'd9) ? 9'h000 : 9'h160;
    return (hi >= 4'd9) ? 9'h166 : 9'h006;
  endfunction

  task automatic model_alu(input e_alu_op op, input t_byte a, input t_byte b,
                           input e_cin_sel cs, input logic inv, input logic adj);
    logic       cin;
    t_byte      opnd;
    logic [8:0] sum;
    logic [8:0] dt;
    logic [4:0] low;
    cin = (cs == CIN_ONE) || (cs == CIN_CCO && m_cco) || (cs == CIN_PSW_CY && m_cy) ||
          (op == ALU_INC);
    dt = daa_table(a, m_cy, m_hc);
    opnd = (op == ALU_INC || op == ALU_DEC) ? 8'h00 : b;
    if (adj)
      opnd = dt[7:0];
    if (inv || op == ALU_DEC)
      opnd = ~opnd;
    case (op)
      ALU_SUM, ALU_INC, ALU_DEC: begin
        sum = {1'b0, a} + {1'b0, opnd} + {8'h00, cin};
        low = {1'b0, a[3:0]} + {1'b0, opnd[3:0]} + {4'h0, cin};
        m_res = sum[7:0];
        m_cco = adj ? dt[8] : sum[8];
        m_cho = (low > 5'd9);
      end
      ALU_OR:  m_res = a | opnd;
      ALU_AND: m_res = a & opnd;
      ALU_EOR: m_res = a ^ opnd;
      ALU_LSL: {m_cco, m_res} = {a, 1'b0};
      ALU_ROL: {m_cco, m_res} = {a, cin};
      ALU_LSR: {m_res, m_cco} = {1'b0, a};
      ALU_ROR: {m_res, m_cco} = {cin, a};
      default: ;
    endcase
  endtask

  // Load both operands, run one op, then copy the flags into the PSW
  task automatic run_alu(input e_alu_op op, input t_byte a, input t_byte b,
                         input e_cin_sel cs, input logic inv, input logic adj);
    @(posedge CLK);
    op_data <= a;
    ai_we   <= 1'b1;
    @(posedge CLK);
    op_data <= b;
    ai_we   <= 1'b0;
    bi_we   <= 1'b1;
    @(posedge CLK);
    bi_we   <= 1'b0;
    alu_go  <= 1'b1;
    alu_op  <= op;
    cin_sel <= cs;
    bi_not  <= inv;
    daa     <= adj;
    @(posedge CLK);
    alu_go  <= 1'b0;
    daa     <= 1'b0;
    psw_upd <= 1'b1;
    model_alu(op, a, b, cs, inv, adj);
    @(negedge CLK);
    compare("alu_result", alu_result, m_res);
    @(posedge CLK);
    psw_upd <= 1'b0;
    m_cy = m_cco;
    m_hc = m_cho;
    @(negedge CLK);
    compare("psw", psw, {1'b0, m_res == 8'h00, 1'b0, m_hc, 3'b000, m_cy});
  endtask

  function automatic t_byte pc_oe_of(t_byte mc);
    t_byte oe;
    oe = 8'b0111_1000;
    oe[7] = ~mc[7];
    oe[1:0] = ~mc[1:0];
    return oe;
  endfunction

  // Mode bit set selects the pin on reads
  function automatic t_byte expected_read(logic [2:0] s, t_byte pbv, t_byte pcv);
    case (s)
      SPR_PA:  return m_pa;
      SPR_PB:  return (m_pb & ~m_mb) | (pbv & m_mb);
      SPR_PC:  return (m_pc & pc_oe_of(m_mc)) | (pcv & ~pc_oe_of(m_mc));
      SPR_MK:  return m_mk;
      SPR_MB:  return m_mb;
      SPR_MC:  return m_mc;
      default: return 8'h00;
    endcase
  endfunction

  function automatic t_byte vector_of(logic [2:0] l);
    if (l[0])
      return `UPD_VEC_INT0;
    if (l[1])
      return `UPD_VEC_INT1;
    if (l[2])
      return `UPD_VEC_INT2;
    return `UPD_VEC_SOFTI;
  endfunction

  task automatic set_ie(input logic v);
    @(posedge CLK);
    ie_we  <= 1'b1;
    ie_val <= v;
    @(posedge CLK);
    ie_we  <= 1'b0;
    m_ie = v;
  endtask

  task automatic check_int();
    @(negedge CLK);
    compare("int_req", {7'b0, int_req}, {7'b0, |m_latched});
    compare("int_vector", int_vector, vector_of(m_latched));
  endtask

  task automatic fetch_and_check();
    @(posedge CLK);
    fetch_start <= 1'b1;
    @(posedge CLK);
    fetch_start <= 1'b0;
    m_latched = m_pend & {m_ie & ~m_mk[3], m_ie & ~m_mk[2], m_ie & ~m_mk[0]};
    check_int();
  endtask

  // INT0 pending follows the pin, so only the edge sources lose their bit
  task automatic ack_and_check();
    @(posedge CLK);
    int_ack <= 1'b1;
    @(posedge CLK);
    int_ack <= 1'b0;
    m_ie = 1'b0;
    if (m_latched[0]) begin
      m_latched[0] = 1'b0;
    end else if (m_latched[1]) begin
      m_latched[1] = 1'b0;
      m_pend[1] = 1'b0;
    end else begin
      m_latched[2] = 1'b0;
      m_pend[2] = 1'b0;
    end
    check_int();
  endtask

  // Called right after a rising edge; 60 cycles hold five sampling ticks
  task automatic ramp_int12();
    int1 <= 1'b0;
    int2 <= 1'b0;
    repeat (60) @(posedge CLK);
    int1 <= 1'b1;
    int2 <= 1'b1;
    repeat (60) @(posedge CLK);
  endtask

  //////////////////////////////////////////////////
  // Test sequence

  initial begin
    logic [2:0] s;
    logic [2:0] r;
    t_byte      v, pbv, pcv;
    logic       lvl;
    seed = 32'h5a5d;
    rst_n = 1'b0;
    spr_sel = SPR_PA;
    spr_wdata = 8'h00;
    spr_we = 1'b0;
    op_data = 8'h00;
    ai_we = 1'b0;
    bi_we = 1'b0;
    alu_go = 1'b0;
    alu_op = ALU_SUM;
    cin_sel = CIN_NONE;
    bi_not = 1'b0;
    daa = 1'b0;
    psw_upd = 1'b0;
    int0 = 1'b0;
    int1 = 1'b0;
    int2 = 1'b0;
    fetch_start = 1'b0;
    int_ack = 1'b0;
    ie_we = 1'b0;
    ie_val = 1'b0;
    pb_in = 8'h00;
    pc_in = 8'h00;
    {m_cco, m_cho, m_cy, m_hc, m_ie} = 5'b0;
    {m_pa, m_pb, m_pc} = 24'h0;
    {m_mk, m_mb, m_mc} = 24'hFFFFFF;
    m_pend = 3'b000;
    m_latched = 3'b000;
    m_res = 8'h00;

    repeat (16) @(posedge CLK);
    rst_n <= 1'b1;
    @(negedge CLK);

    // Reset state
    compare("psw", psw, 8'h00);
    compare("int_req", {7'b0, int_req}, 8'h00);
    compare("int_vector", int_vector, `UPD_VEC_SOFTI);
    compare("pb_oe", pb_oe, 8'h00);
    compare("pa_out", pa_out, 8'h00);
    compare("pb_out", pb_out, 8'h00);
    compare("pc_out", pc_out, 8'h00);
    for (int i = 3; i < 6; i++) begin
      @(posedge CLK);
      spr_sel <= e_spr'(3'(i));
      @(negedge CLK);
      compare("spr_rdata", spr_rdata, 8'hFF);
    end

    // Random ALU operations, CCO chains through the model
    for (int i = 0; i < 400; i++) begin
      run_alu(e_alu_op'(4'(rand_below(10))), 8'($random(seed)), 8'($random(seed)),
              e_cin_sel'(2'(rand_below(4))), 1'(rand_below(2)), 1'b0);
    end

    // BCD sums followed by decimal adjust
    for (int i = 0; i < 100; i++) begin
      v = {4'(rand_below(10)), 4'(rand_below(10))};
      run_alu(ALU_SUM, v, {4'(rand_below(10)), 4'(rand_below(10))}, CIN_NONE, 1'b0, 1'b0);
      run_alu(ALU_SUM, m_res, 8'h00, CIN_NONE, 1'b0, 1'b1);
    end

    // Special-register writes and reads
    for (int i = 0; i < 200; i++) begin
      s = 3'(rand_below(6));
      v = 8'($random(seed));
      // INT2 stays active high so no INT2 edge appears
      if (s == SPR_MK)
        v[`UPD_MK_INT2_POL] = 1'b1;
      pbv = 8'($random(seed));
      pcv = 8'($random(seed));
      @(posedge CLK);
      spr_sel   <= e_spr'(s);
      spr_wdata <= v;
      spr_we    <= 1'b1;
      pb_in     <= pbv;
      pc_in     <= pcv;
      case (s)
        SPR_PA:  m_pa = v;
        SPR_PB:  m_pb = v;
        SPR_PC:  m_pc = v;
        SPR_MK:  m_mk = v;
        SPR_MB:  m_mb = v;
        default: m_mc = v;
      endcase
      r = 3'(rand_below(8));
      @(posedge CLK);
      spr_we  <= 1'b0;
      spr_sel <= e_spr'(r);
      @(negedge CLK);
      compare("pa_out", pa_out, m_pa);
      compare("pb_out", pb_out, m_pb);
      compare("pc_out", pc_out, m_pc);
      compare("pb_oe", pb_oe, ~m_mb);
      compare("pc_oe", pc_oe, pc_oe_of(m_mc));
      compare("spr_rdata", spr_rdata, expected_read(r, pbv, pcv));
    end

    // INT0 level with random mask and enable
    for (int i = 0; i < 100; i++) begin
      lvl = (rand_below(4) != 0);
      v = 8'($random(seed)) | 8'h20;
      @(posedge CLK);
      int0      <= lvl;
      spr_sel   <= SPR_MK;
      spr_wdata <= v;
      spr_we    <= 1'b1;
      @(posedge CLK);
      spr_we <= 1'b0;
      m_pend[0] = lvl;
      m_mk = v;
      set_ie(rand_below(4) != 0);
      fetch_and_check();
      if (|m_latched) begin
        ack_and_check();
        // ie is gone, so a new fetch latches nothing
        fetch_and_check();
      end
    end
    @(posedge CLK);
    int0 <= 1'b0;
    m_pend[0] = 1'b0;

    // INT1 and INT2 edges, INT2 active high
    @(posedge CLK);
    spr_sel   <= SPR_MK;
    spr_wdata <= 8'h21;
    spr_we    <= 1'b1;
    @(posedge CLK);
    spr_we <= 1'b0;
    m_mk = 8'h21;
    ramp_int12();
    m_pend[2:1] = 2'b11;
    set_ie(1'b1);
    fetch_and_check();
    ack_and_check();
    ack_and_check();
    set_ie(1'b1);
    fetch_and_check();

    // INT2 active low, the same pin pattern is no INT2 edge
    // Pin and polarity flip on one edge so the sampled INT2 never dips
    @(posedge CLK);
    spr_wdata <= 8'h01;
    spr_we    <= 1'b1;
    @(posedge CLK);
    spr_we <= 1'b0;
    m_mk = 8'h01;
    ramp_int12();
    m_pend[1] = 1'b1;
    set_ie(1'b1);
    fetch_and_check();
    ack_and_check();
    set_ie(1'b1);
    fetch_and_check();

    repeat (4) @(posedge CLK);
    $display("errors: %0d mismatches in %0d checks", errors, checks);
    if (errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

// ==== tb.f ====
+incdir+design
design/upd7800_pkg.sv
design/spr_bus_if.sv
design/alu_unit.sv
design/int_ctrl.sv
design/port_regs.sv
design/upd7800_slice.sv
tests/tb_upd7800_slice.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the uPD7800 slice testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ns \
  -f tb.f --top-module tb_upd7800_slice -o sim_tb

out=$(./obj_dir/sim_tb || true)
echo "$out"

if echo "$out" | grep -q "SIMULATION PASSED"; then
  exit 0
fi
exit 1
